// ==== Makefile ====
VERILATOR  = verilator
TOP        = dataflowTb
FILELIST   = project.f
SIM_FLAGS  = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_TEXT  = Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== project.f ====
src/dataflowPkg.sv
src/internalBus.sv
src/busRegister.sv
src/instrDecode.sv
src/executeStage.sv
src/dataflowTop.sv
testbench/dataflowTb.sv

// ==== src/busRegister.sv ====
`timescale 1ns/100ps
`default_nettype none

// Byte register sitting between several buses
// Loads from any enabled input, drives any enabled output
module busRegister
#(
  parameter int         INPUT_COUNT  = 1,
  parameter int         OUTPUT_COUNT = 1,
  parameter logic [7:0] RESET_VALUE  = 8'h00
)
(
  input  logic                      clk,
  input  logic                      nrst,
  input  logic [8*INPUT_COUNT-1:0]  busInputs,
  input  logic [INPUT_COUNT-1:0]    readEnable,
  output logic [8*OUTPUT_COUNT-1:0] busOutputs,
  input  logic [OUTPUT_COUNT-1:0]   writeEnable
);

  logic [7:0] currentState;
  logic [7:0] nextState;
  // OR of all enabled input lanes
  logic [7:0] mergedInput;

  // Gate each input lane by its read enable
  // Several enables at once give the bitwise OR
  always_comb
  begin
    mergedInput = 8'h00;
    for (int i = 0; i < INPUT_COUNT; i++)
    begin
      if (readEnable[i])
      begin
        mergedInput = mergedInput | busInputs[8*i +: 8];
      end
    end
  end

  // Load on any enable, otherwise hold
  always_comb
  begin
    if (|readEnable)
    begin
      nextState = mergedInput;
    end
    else
    begin
      nextState = currentState;
    end
  end

  // State register
  always_ff @(posedge clk, negedge nrst)
  begin
    if (!nrst)
    begin
      currentState <= RESET_VALUE;
    end
    else
    begin
      currentState <= nextState;
    end
  end

  // Output lanes, zero when not enabled so they can share a bus
  generate
    for (genvar i = 0; i < OUTPUT_COUNT; i++)
    begin : gOutLane
      assign busOutputs[8*i +: 8] = writeEnable[i] ? currentState : 8'h00;
    end
  endgenerate

endmodule

`default_nettype wire

// ==== src/dataflowPkg.sv ====
`default_nettype none

package dataflowPkg;

  // Register file size, fixed by the 2-bit index
  localparam int REG_COUNT = 4;

  // Register number R0 to R3
  typedef logic [1:0] regIdx_t;

  // Operation codes
  // Codes above OUT are unused and act as NOP
  typedef enum logic [3:0] {
    NOP   = 4'h0,
    LOADI = 4'h1,
    INPUT = 4'h2,
    MOVE  = 4'h3,
    ADD   = 4'h4,
    SUB   = 4'h5,
    AND   = 4'h6,
    OR    = 4'h7,
    XOR   = 4'h8,
    OUT   = 4'h9
  } opcode_t;

  // Register form, two sources and a destination
  typedef struct packed {
    opcode_t    opcode;
    regIdx_t    dst;
    regIdx_t    srcA;
    regIdx_t    srcB;
    logic [5:0] pad;
  } regForm_t;

  // Immediate form, destination plus an 8-bit constant
  typedef struct packed {
    opcode_t    opcode;
    regIdx_t    dst;
    logic [1:0] pad;
    logic [7:0] imm;
  } immForm_t;

  // One 16-bit word, two readings
  // Opcode sits in bits 15 to 12 in both
  typedef union packed {
    regForm_t regForm;
    immForm_t immForm;
  } instr_t;

  // Decoded control handed from decode to execute
  typedef struct packed {
    logic       valid;
    opcode_t    op;
    regIdx_t    dst;
    regIdx_t    srcA;
    regIdx_t    srcB;
    logic [7:0] imm;
    // Destination register gets loaded
    logic       writeReg;
    // Load from dataIn instead of the ALU
    logic       useInput;
    // Drive bus A out on the output port
    logic       emitOut;
  } execCtrl_t;

endpackage

`default_nettype wire

// ==== src/dataflowTop.sv ====
`timescale 1ns/100ps
`default_nettype none

// Two-stage bus datapath
// Decode on the first edge, execute and write back on the second
module dataflowTop
  import dataflowPkg::*;
#(
  // Value every register takes at reset
  parameter logic [7:0] RESET_VALUE = 8'hAA
)
(
  input  logic       clk,
  input  logic       nrst,
  input  logic       instrValid,
  input  instr_t     instrWord,
  input  logic [7:0] dataIn,
  output logic       outValid,
  output logic [7:0] outData
);

  // Registered control between the stages
  execCtrl_t ctrl;

  instrDecode u_instrDecode (
    .clk       (clk),
    .nrst      (nrst),
    .instrValid(instrValid),
    .instrWord (instrWord),
    .ctrl      (ctrl)
  );

  executeStage #(
    .RESET_VALUE(RESET_VALUE)
  ) u_executeStage (
    .clk     (clk),
    .nrst    (nrst),
    .ctrl    (ctrl),
    .dataIn  (dataIn),
    .outValid(outValid),
    .outData (outData)
  );

endmodule

`default_nettype wire

// ==== src/executeStage.sv ====
`timescale 1ns/100ps
`default_nettype none

// Stage 2
// Register file on two ORed operand buses, ALU, write-back and output port
module executeStage
  import dataflowPkg::*;
#(
  parameter logic [7:0] RESET_VALUE = 8'hAA
)
(
  input  logic       clk,
  input  logic       nrst,
  input  execCtrl_t  ctrl,
  input  logic [7:0] dataIn,
  output logic       outValid,
  output logic [7:0] outData
);

  // One-hot output enables onto bus A and bus B
  logic [REG_COUNT-1:0] selA;
  logic [REG_COUNT-1:0] selB;
  // Destination register of a writing instruction
  logic [REG_COUNT-1:0] loadSel;
  // Per register, lane 0 loads the ALU, lane 1 loads dataIn
  logic [REG_COUNT-1:0][1:0] regRead;

  // Gated register lanes feeding each bus
  logic [REG_COUNT-1:0][7:0] laneA;
  logic [REG_COUNT-1:0][7:0] laneB;

  logic [7:0] busA;
  logic [7:0] busB;
  logic [7:0] aluResult;

  // Index decode, nothing is selected on an idle cycle
  always_comb
  begin
    for (int i = 0; i < REG_COUNT; i++)
    begin
      selA[i]    = ctrl.valid && (ctrl.srcA == regIdx_t'(i));
      selB[i]    = ctrl.valid && (ctrl.srcB == regIdx_t'(i));
      loadSel[i] = ctrl.valid && ctrl.writeReg && (ctrl.dst == regIdx_t'(i));
      regRead[i][0] = loadSel[i] && !ctrl.useInput;
      regRead[i][1] = loadSel[i] && ctrl.useInput;
    end
  end

  // Register file, each register sees both buses and both load sources
  generate
    for (genvar i = 0; i < REG_COUNT; i++)
    begin : gReg
      busRegister #(
        .INPUT_COUNT (2),
        .OUTPUT_COUNT(2),
        .RESET_VALUE (RESET_VALUE)
      ) u_busRegister (
        .clk        (clk),
        .nrst       (nrst),
        .busInputs  ({dataIn, aluResult}),
        .readEnable (regRead[i]),
        .busOutputs ({laneB[i], laneA[i]}),
        .writeEnable({selB[i], selA[i]})
      );
    end
  endgenerate

  // Operand bus A
  internalBus #(
    .DRIVER_COUNT(REG_COUNT)
  ) u_busA (
    .busInputs(laneA),
    .busOutput(busA)
  );

  // Operand bus B
  internalBus #(
    .DRIVER_COUNT(REG_COUNT)
  ) u_busB (
    .busInputs(laneB),
    .busOutput(busB)
  );

  // ALU, all results wrap modulo 256
  always_comb
  begin
    case (ctrl.op)
      LOADI:   aluResult = ctrl.imm;
      MOVE:    aluResult = busA;
      ADD:     aluResult = busA + busB;
      SUB:     aluResult = busA - busB;
      AND:     aluResult = busA & busB;
      OR:      aluResult = busA | busB;
      XOR:     aluResult = busA ^ busB;
      // INPUT loads through the dataIn lane instead
      default: aluResult = 8'h00;
    endcase
  end

  // Output port, one-cycle pulse per OUT
  always_ff @(posedge clk, negedge nrst)
  begin
    if (!nrst)
    begin
      outValid <= 1'b0;
      outData  <= 8'h00;
    end
    else
    begin
      outValid <= ctrl.valid && ctrl.emitOut;
      // Byte stays put between pulses
      if (ctrl.valid && ctrl.emitOut)
      begin
        outData <= busA;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/instrDecode.sv ====
`timescale 1ns/100ps
`default_nettype none

// Stage 1
// Samples the instruction word and registers the decoded control
module instrDecode
  import dataflowPkg::*;
(
  input  logic      clk,
  input  logic      nrst,
  input  logic      instrValid,
  input  instr_t    instrWord,
  output execCtrl_t ctrl
);

  // Control decoded from the incoming word, before the register
  execCtrl_t decoded;

  always_comb
  begin
    decoded       = '0;
    decoded.valid = instrValid;
    decoded.op    = instrWord.regForm.opcode;

    // Register indices through the register view
    decoded.dst  = instrWord.regForm.dst;
    decoded.srcA = instrWord.regForm.srcA;
    decoded.srcB = instrWord.regForm.srcB;

    // Constant through the immediate view of the same bits
    decoded.imm = instrWord.immForm.imm;

    case (instrWord.regForm.opcode)
      LOADI, MOVE, ADD, SUB, AND, OR, XOR:
      begin
        decoded.writeReg = 1'b1;
      end
      INPUT:
      begin
        // Result comes from dataIn, not the ALU
        decoded.writeReg = 1'b1;
        decoded.useInput = 1'b1;
      end
      OUT:
      begin
        decoded.emitOut = 1'b1;
      end
      default:
      begin
        // NOP and unused codes touch nothing
        decoded.writeReg = 1'b0;
      end
    endcase
  end

  // Pipeline register between decode and execute
  always_ff @(posedge clk, negedge nrst)
  begin
    if (!nrst)
    begin
      ctrl <= '0;
    end
    else
    begin
      ctrl <= decoded;
    end
  end

endmodule

`default_nettype wire

// ==== src/internalBus.sv ====
`timescale 1ns/100ps
`default_nettype none

// Shared byte bus
// Every driver gates itself to zero when idle, so the bus is a plain OR
module internalBus
#(
  parameter int DRIVER_COUNT = 2
)
(
  input  logic [8*DRIVER_COUNT-1:0] busInputs,
  output logic [7:0]                busOutput
);

  // Running OR, lane i holds drivers 0 through i combined
  logic [8*DRIVER_COUNT-1:0] orChain;

  // Base of the chain is the first driver
  assign orChain[7:0] = busInputs[7:0];

  generate
    for (genvar i = 1; i < DRIVER_COUNT; i++)
    begin : gOrChain
      // Fold driver i into the lanes before it
      assign orChain[8*i+7:8*i] = orChain[8*i-1:8*i-8] | busInputs[8*i+7:8*i];
    end
  endgenerate

  // Top lane carries every driver, zero if none is active
  assign busOutput = orChain[8*DRIVER_COUNT-1:8*DRIVER_COUNT-8];

endmodule

`default_nettype wire

// ==== testbench/dataflowTb.sv ====
`timescale 1ns/100ps
`default_nettype none

// Table-driven testbench for the two-stage datapath
// Entries issue back to back, a monitor matches outputs in issue order
module dataflowTb
  import dataflowPkg::*;
();

  // One row of the stimulus table
  typedef struct packed {
    instr_t     word;
    logic [7:0] din;
    logic       expOut;
    logic [7:0] expByte;
    logic       endOfTest;
  } entry_t;

  localparam logic [7:0] RESET_BYTE  = 8'hAA;
  localparam int         OUT_TIMEOUT = 20;

  logic       clk;
  logic       nrst;
  logic       instrValid;
  instr_t     instrWord;
  logic [7:0] dataIn;
  logic       outValid;
  logic [7:0] outData;

  // dataIn is consumed one cycle after its instruction
  logic [7:0] stagedData;
  logic [7:0] expectedByte;

  entry_t     stimTable[$];
  string      testNames[$];
  logic [7:0] expQueue[$];
  // Reference copy of R0 to R3
  logic [7:0] model[REG_COUNT];
  integer     seed = 32'h806d_c731;
  int         errorCount;
  int         passCount;
  int         failCount;
  int         testIndex;

  dataflowTop #(
    .RESET_VALUE(RESET_BYTE)
  ) u_dataflowTop (
    .clk       (clk),
    .nrst      (nrst),
    .instrValid(instrValid),
    .instrWord (instrWord),
    .dataIn    (dataIn),
    .outValid  (outValid),
    .outData   (outData)
  );

  always #5 clk = ~clk;

  // Delay line so dataIn lines up with the execute cycle
  always @(posedge clk)
  begin
    dataIn <= stagedData;
  end

  task automatic compareValue(input string name, input logic [7:0] actual,
                              input logic [7:0] expected);
    if (actual !== expected)
    begin
      $display("Error at %0t: %s is 8'h%02h, expected 8'h%02h", $time, name, actual, expected);
      errorCount++;
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk)
  begin
    if (nrst && outValid)
    begin
      if (expQueue.size() == 0)
      begin
        $display("Unexpected outValid pulse at %0t with no OUT outstanding", $time);
        errorCount++;
      end
      else
      begin
        expectedByte = expQueue.pop_front();
        compareValue("outData", outData, expectedByte);
      end
    end
  end

  function automatic logic [7:0] randomByte();
    return 8'($random(seed));
  endfunction

  // Encode one instruction and advance the reference registers
  task automatic addEntry(input logic [3:0] op, input regIdx_t dst, input regIdx_t srcA,
                          input regIdx_t srcB, input logic [7:0] imm, input logic [7:0] din);
    entry_t e;
    e = '0;
    // Immediate form keeps the constant in the low byte
    if (op == LOADI)
    begin
      e.word = {op, dst, 2'b00, imm};
    end
    else
    begin
      e.word = {op, dst, srcA, srcB, 6'b000000};
    end
    e.din = din;
    case (op)
      LOADI: model[dst] = imm;
      INPUT: model[dst] = din;
      MOVE:  model[dst] = model[srcA];
      ADD:   model[dst] = model[srcA] + model[srcB];
      SUB:   model[dst] = model[srcA] - model[srcB];
      AND:   model[dst] = model[srcA] & model[srcB];
      OR:    model[dst] = model[srcA] | model[srcB];
      XOR:   model[dst] = model[srcA] ^ model[srcB];
      OUT:
      begin
        e.expOut  = 1'b1;
        e.expByte = model[srcA];
      end
      // NOP and unused codes change nothing
      default: ;
    endcase
    stimTable.push_back(e);
  endtask

  // Mark the last entry as the end of a named test
  task automatic closeTest(input string name);
    entry_t e;
    e = stimTable.pop_back();
    e.endOfTest = 1'b1;
    stimTable.push_back(e);
    testNames.push_back(name);
  endtask

  task automatic readAll();
    for (int r = 0; r < REG_COUNT; r++)
    begin
      addEntry(OUT, 2'd0, regIdx_t'(r), 2'd0, 8'h00, 8'h00);
    end
  endtask

  task automatic buildTable();
    logic [3:0] aluOps[5];
    logic [3:0] op;
    aluOps = '{ADD, SUB, AND, OR, XOR};
    readAll();
    closeTest("reset value");

    for (int r = 0; r < REG_COUNT; r++)
    begin
      addEntry(LOADI, regIdx_t'(r), 2'd0, 2'd0, randomByte(), 8'h00);
      addEntry(OUT, 2'd0, regIdx_t'(r), 2'd0, 8'h00, 8'h00);
      addEntry(INPUT, regIdx_t'(r), 2'd0, 2'd0, 8'h00, randomByte());
      addEntry(OUT, 2'd0, regIdx_t'(r), 2'd0, 8'h00, 8'h00);
    end
    closeTest("immediate and input loads");

    // Both operand orders so SUB is seen in each direction
    for (int k = 0; k < 5; k++)
    begin
      addEntry(LOADI, 2'd0, 2'd0, 2'd0, randomByte(), 8'h00);
      addEntry(LOADI, 2'd1, 2'd0, 2'd0, randomByte(), 8'h00);
      addEntry(aluOps[k], 2'd2, 2'd0, 2'd1, 8'h00, 8'h00);
      addEntry(aluOps[k], 2'd3, 2'd1, 2'd0, 8'h00, 8'h00);
      addEntry(MOVE, 2'd0, 2'd3, 2'd0, 8'h00, 8'h00);
      readAll();
    end
    closeTest("ALU operations");

    // Dependent chain, then a random stream with no gaps
    addEntry(LOADI, 2'd1, 2'd0, 2'd0, randomByte(), 8'h00);
    addEntry(ADD, 2'd2, 2'd1, 2'd1, 8'h00, 8'h00);
    addEntry(OUT, 2'd0, 2'd2, 2'd0, 8'h00, 8'h00);
    readAll();
    for (int n = 0; n < 32; n++)
    begin
      op = 4'(1 + $unsigned($random(seed)) % 9);
      addEntry(op, regIdx_t'($random(seed)), regIdx_t'($random(seed)),
               regIdx_t'($random(seed)), randomByte(), randomByte());
    end
    readAll();
    closeTest("back-to-back instructions");

    // NOP and every unused code with random fields
    for (int c = 0; c < 16; c++)
    begin
      if (c == 0 || c > 9)
      begin
        addEntry(4'(c), regIdx_t'($random(seed)), regIdx_t'($random(seed)),
                 regIdx_t'($random(seed)), randomByte(), randomByte());
      end
    end
    readAll();
    closeTest("no spurious output");
  endtask

  // Wait for all outstanding OUT results, then watch a quiet bus
  task automatic drainOutputs(input string name);
    int waited;
    waited = 0;
    while (expQueue.size() != 0 && waited < OUT_TIMEOUT)
    begin
      @(posedge clk);
      waited++;
    end
    if (expQueue.size() != 0)
    begin
      $display("Test %s timed out, %0d outValid pulses never arrived", name, expQueue.size());
      errorCount++;
      expQueue.delete();
    end
    // Monitor flags any pulse in these cycles
    repeat (3) @(posedge clk);
  endtask

  initial
  begin
    int     errorsBefore;
    entry_t e;
    clk        = 1'b0;
    nrst       = 1'b0;
    instrValid = 1'b0;
    instrWord  = '0;
    dataIn     = 8'h00;
    stagedData = 8'h00;
    errorCount = 0;
    passCount  = 0;
    failCount  = 0;
    testIndex  = 0;
    for (int r = 0; r < REG_COUNT; r++)
    begin
      model[r] = RESET_BYTE;
    end
    buildTable();

    repeat (16) @(posedge clk);
    nrst <= 1'b1;
    errorsBefore = 0;

    for (int i = 0; i < stimTable.size(); i++)
    begin
      e = stimTable[i];
      @(posedge clk);
      instrValid <= 1'b1;
      instrWord  <= e.word;
      stagedData <= e.din;
      if (e.expOut)
      begin
        expQueue.push_back(e.expByte);
      end
      if (e.endOfTest)
      begin
        @(posedge clk);
        instrValid <= 1'b0;
        drainOutputs(testNames[testIndex]);
        if (errorCount == errorsBefore)
        begin
          passCount++;
          $display("Test %0d (%s) passed", testIndex + 1, testNames[testIndex]);
        end
        else
        begin
          failCount++;
          $display("Test %0d (%s) failed with %0d errors", testIndex + 1,
                   testNames[testIndex], errorCount - errorsBefore);
        end
        testIndex++;
        errorsBefore = errorCount;
      end
    end

    $display("Tests passed: %0d, tests failed: %0d", passCount, failCount);
    if (failCount == 0 && errorCount == 0)
    begin
      $display("Simulation finished: PASS");
    end
    else
    begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
